/* alu_pkg.sv */
`default_nettype none

package alu_pkg;

    parameter int XLEN = 64;

    // opcodes seen by the execute unit, grouped by the datapath that serves them
    typedef enum logic [4:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_PASS_A = 5'd2,
        ALU_PASS_B = 5'd3,
        ALU_XOR    = 5'd4,
        ALU_OR     = 5'd5,
        ALU_AND    = 5'd6,
        ALU_SLL    = 5'd7,
        ALU_SRL    = 5'd8,
        ALU_SRA    = 5'd9,
        ALU_SLT    = 5'd10,
        ALU_SLTU   = 5'd11,
        ALU_EQ     = 5'd12,
        ALU_GE     = 5'd13,
        ALU_GEU    = 5'd14,
        ALU_MUL    = 5'd15,  // iterative multiplier
        ALU_DIV    = 5'd16,  // iterative divider from here on
        ALU_DIVU   = 5'd17,
        ALU_REM    = 5'd18,
        ALU_REMU   = 5'd19
    } alu_op_e;

    // first operand comes from the pc or from rs1
    typedef enum logic {
        SEL_A_PC  = 1'b0,
        SEL_A_RS1 = 1'b1
    } sel_a_e;

    typedef enum logic [1:0] {
        SEL_B_RS2 = 2'd0,
        SEL_B_CSR = 2'd1,
        SEL_B_IMM = 2'd2
    } sel_b_e;

endpackage

`default_nettype wire

/* alu_simple.sv */
`default_nettype none

module alu_simple
    import alu_pkg::*;
#(
    parameter int XLEN = alu_pkg::XLEN
) (
    input  wire alu_op_e    op,
    input  wire [XLEN-1:0]  a,
    input  wire [XLEN-1:0]  b,
    input  wire             word,
    output logic [XLEN-1:0] simple_res
);

    localparam int SW = $clog2(XLEN);

    logic [SW-1:0]   shamt;
    logic [31:0]     sra_w;
    logic [XLEN-1:0] sra_d;

    assign shamt = b[SW-1:0];

    // word sra shifts the low half on its own and the result is zero-extended
    assign sra_w = $signed(a[31:0]) >>> shamt;
    assign sra_d = $signed(a) >>> shamt;

    always_comb begin
        simple_res = '0;  // iterative opcodes leave zero here
        case (op)
            ALU_ADD:    simple_res = a + b;
            ALU_SUB:    simple_res = a - b;
            ALU_PASS_A: simple_res = a;
            ALU_PASS_B: simple_res = b;
            ALU_XOR:    simple_res = a ^ b;
            ALU_OR:     simple_res = a | b;
            ALU_AND:    simple_res = a & b;
            ALU_SLL:    simple_res = a << shamt;
            ALU_SRL:    simple_res = a >> shamt;
            ALU_SRA: begin
                if (word)
                    simple_res = {{(XLEN-32){1'b0}}, sra_w};
                else
                    simple_res = sra_d;
            end
            ALU_SLT:    simple_res[0] = $signed(a) < $signed(b);
            ALU_SLTU:   simple_res[0] = a < b;
            ALU_EQ:     simple_res[0] = a == b;
            ALU_GE:     simple_res[0] = $signed(a) >= $signed(b);
            ALU_GEU:    simple_res[0] = a >= b;
            default:    simple_res = '0;
        endcase
    end

endmodule

`default_nettype wire

/* iter_mul.sv */
`default_nettype none

module iter_mul #(
    parameter int XLEN = alu_pkg::XLEN
) (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             start,
    input  wire             flush,
    input  wire [XLEN-1:0]  a,
    input  wire [XLEN-1:0]  b,
    output logic            done,
    output logic [XLEN-1:0] product
);

    localparam int CW = $clog2(XLEN) + 1;

    logic            busy;
    logic [CW-1:0]   cnt;
    logic [XLEN-1:0] mcand;
    logic [XLEN-1:0] mplier;
    logic [XLEN-1:0] product_q;

    assign product = product_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else if (flush) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                busy <= 1'b1;
                cnt  <= CW'(1);  // bit 0 is consumed in the start cycle
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == CW'(XLEN - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // only the low word of the product is kept so partial products can be truncated
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            product_q <= b[0] ? a : '0;
            mcand     <= a << 1;
            mplier    <= b >> 1;
        end else if (busy) begin
            product_q <= product_q + (mplier[0] ? mcand : '0);
            mcand     <= mcand << 1;
            mplier    <= mplier >> 1;
        end
    end

endmodule

`default_nettype wire

/* iter_div.sv */
`default_nettype none

module iter_div #(
    parameter int XLEN = alu_pkg::XLEN
) (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             start,
    input  wire             flush,
    input  wire             signed_op,
    input  wire [XLEN-1:0]  dividend,
    input  wire [XLEN-1:0]  divisor,
    output logic            done,
    output logic [XLEN-1:0] quotient,
    output logic [XLEN-1:0] remainder
);

    localparam int CW = $clog2(XLEN) + 1;

    logic            busy;
    logic [CW-1:0]   cnt;
    logic [XLEN-1:0] quo;
    logic [XLEN-1:0] rem;
    logic [XLEN-1:0] dsor;
    logic [XLEN-1:0] dvd_raw;
    logic            neg_q;
    logic            neg_r;
    logic            div_zero;
    logic            ovf;
    logic            dvd_neg;
    logic            dsor_neg;
    logic [XLEN:0]   rem_shift;
    logic [XLEN:0]   diff;

    assign dvd_neg  = signed_op && dividend[XLEN-1];
    assign dsor_neg = signed_op && divisor[XLEN-1];

    assign rem_shift = {rem, quo[XLEN-1]};
    assign diff      = rem_shift - {1'b0, dsor};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else if (flush) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == CW'(XLEN - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            // the start cycle does the sign handling and the special case checks
            quo      <= dvd_neg ? -dividend : dividend;
            dsor     <= dsor_neg ? -divisor : divisor;
            rem      <= '0;
            dvd_raw  <= dividend;
            neg_q    <= dvd_neg ^ dsor_neg;
            neg_r    <= dvd_neg;
            div_zero <= divisor == '0;
            ovf      <= signed_op && dividend == {1'b1, {(XLEN-1){1'b0}}} && &divisor;
        end else if (busy) begin
            if (!diff[XLEN]) begin
                rem <= diff[XLEN-1:0];
                quo <= {quo[XLEN-2:0], 1'b1};
            end else begin
                rem <= rem_shift[XLEN-1:0];  // restore
                quo <= {quo[XLEN-2:0], 1'b0};
            end
        end
    end

    always_comb begin
        quotient  = neg_q ? -quo : quo;
        remainder = neg_r ? -rem : rem;
        if (div_zero) begin
            quotient  = '1;
            remainder = dvd_raw;
        end else if (ovf) begin
            quotient  = dvd_raw;
            remainder = '0;
        end
    end

endmodule

`default_nettype wire

/* exec_ctrl.sv */
`default_nettype none

module exec_ctrl
    import alu_pkg::*;
#(
    parameter int XLEN        = alu_pkg::XLEN,
    parameter int OUT_CREDITS = 2
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              flush,
    input  wire              in_valid,
    input  wire alu_op_e     op,
    input  wire sel_a_e      sel_a,
    input  wire sel_b_e      sel_b,
    input  wire              word,
    input  wire [XLEN-1:0]   pc,
    input  wire [XLEN-1:0]   rs1,
    input  wire [XLEN-1:0]   rs2,
    input  wire [XLEN-1:0]   csr,
    input  wire [XLEN-1:0]   imm,
    input  wire              out_credit,
    input  wire [XLEN-1:0]   simple_res,
    input  wire              mul_done,
    input  wire [XLEN-1:0]   mul_res,
    input  wire              div_done,
    input  wire [XLEN-1:0]   div_q,
    input  wire [XLEN-1:0]   div_r,
    output logic             in_credit,
    output logic             out_valid,
    output logic [XLEN-1:0]  res,
    output logic [XLEN-1:0]  a,
    output logic [XLEN-1:0]  b,
    output logic             word_q,
    output logic             mul_start,
    output logic             div_start,
    output logic             div_signed
);

    localparam int CW = $clog2(OUT_CREDITS + 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_EXEC,
        S_MUL_WAIT,
        S_DIV_WAIT,
        S_SEND
    } state_e;

    state_e          state;
    alu_op_e         op_q;
    logic [CW-1:0]   credits;
    logic            boot;
    logic [XLEN-1:0] a_sel;
    logic [XLEN-1:0] b_sel;
    logic            is_div;
    logic            use_rem;

    always_comb begin
        a_sel = (sel_a == SEL_A_PC) ? pc : rs1;
        if (word)
            a_sel = {{(XLEN-32){1'b0}}, a_sel[31:0]};  // word ops see only the low half of a
        case (sel_b)
            SEL_B_RS2: b_sel = rs2;
            SEL_B_CSR: b_sel = csr;
            default:   b_sel = imm;
        endcase
    end

    assign is_div     = op_q inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
    assign use_rem    = op_q inside {ALU_REM, ALU_REMU};
    assign div_signed = op_q inside {ALU_DIV, ALU_REM};

    // the iterative units sample their operands in the exec cycle
    assign mul_start = (state == S_EXEC) && (op_q == ALU_MUL);
    assign div_start = (state == S_EXEC) && is_div;

    assign out_valid = (state == S_SEND) && (credits != '0) && !flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else if (flush && state != S_IDLE) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:     if (in_valid) state <= S_EXEC;
                S_EXEC: begin
                    if (op_q == ALU_MUL)
                        state <= S_MUL_WAIT;
                    else if (is_div)
                        state <= S_DIV_WAIT;
                    else
                        state <= S_SEND;
                end
                S_MUL_WAIT: if (mul_done) state <= S_SEND;
                S_DIV_WAIT: if (div_done) state <= S_SEND;
                S_SEND:     if (out_valid) state <= S_IDLE;
                default:    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && in_valid) begin
            a      <= a_sel;
            b      <= b_sel;
            word_q <= word;
            op_q   <= op;
        end
        case (state)
            S_EXEC:     res <= simple_res;  // overwritten later for iterative ops
            S_MUL_WAIT: if (mul_done) res <= mul_res;
            S_DIV_WAIT: if (div_done) res <= use_rem ? div_r : div_q;
            default:    res <= res;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CW'(OUT_CREDITS);
        end else begin
            case ({out_valid, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // one credit goes upstream after reset, then one per retired or flushed operation
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            boot      <= 1'b1;
            in_credit <= 1'b0;
        end else begin
            boot      <= 1'b0;
            in_credit <= boot || out_valid || (flush && state != S_IDLE);
        end
    end

endmodule

`default_nettype wire

/* exec_unit.sv */
`default_nettype none

module exec_unit
    import alu_pkg::*;
#(
    parameter int XLEN        = alu_pkg::XLEN,
    parameter int OUT_CREDITS = 2
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              flush,
    input  wire              in_valid,
    input  wire alu_op_e     op,
    input  wire sel_a_e      sel_a,
    input  wire sel_b_e      sel_b,
    input  wire              word,
    input  wire [XLEN-1:0]   pc,
    input  wire [XLEN-1:0]   rs1,
    input  wire [XLEN-1:0]   rs2,
    input  wire [XLEN-1:0]   csr,
    input  wire [XLEN-1:0]   imm,
    output logic             in_credit,
    output logic             out_valid,
    output logic [XLEN-1:0]  res,
    input  wire              out_credit
);

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic            word_q;
    logic [XLEN-1:0] simple_res;
    logic            mul_start;
    logic            mul_done;
    logic [XLEN-1:0] mul_res;
    logic            div_start;
    logic            div_signed;
    logic            div_done;
    logic [XLEN-1:0] div_q;
    logic [XLEN-1:0] div_r;

    exec_ctrl #(
        .XLEN        (XLEN),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .in_valid   (in_valid),
        .op         (op),
        .sel_a      (sel_a),
        .sel_b      (sel_b),
        .word       (word),
        .pc         (pc),
        .rs1        (rs1),
        .rs2        (rs2),
        .csr        (csr),
        .imm        (imm),
        .out_credit (out_credit),
        .simple_res (simple_res),
        .mul_done   (mul_done),
        .mul_res    (mul_res),
        .div_done   (div_done),
        .div_q      (div_q),
        .div_r      (div_r),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .res        (res),
        .a          (a),
        .b          (b),
        .word_q     (word_q),
        .mul_start  (mul_start),
        .div_start  (div_start),
        .div_signed (div_signed)
    );

    alu_simple #(.XLEN(XLEN)) u_simple (
        .op         (op),
        .a          (a),
        .b          (b),
        .word       (word_q),
        .simple_res (simple_res)
    );

    iter_mul #(.XLEN(XLEN)) u_mul (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (mul_start),
        .flush   (flush),
        .a       (a),
        .b       (b),
        .done    (mul_done),
        .product (mul_res)
    );

    iter_div #(.XLEN(XLEN)) u_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (div_start),
        .flush     (flush),
        .signed_op (div_signed),
        .dividend  (a),
        .divisor   (b),
        .done      (div_done),
        .quotient  (div_q),
        .remainder (div_r)
    );

endmodule

`default_nettype wire

/* tb_clkgen.sv */
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;  // released half a cycle away from the rising edge
    end

endmodule

`default_nettype wire

/* exec_unit_tb.sv */
`default_nettype none

module exec_unit_tb
    import alu_pkg::*;
#(
    parameter int OUT_CREDITS = 2
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CREDIT_WAIT = 200;
    localparam int RESULT_WAIT = 200;  // the slowest op, a divide, needs about 67 cycles

    localparam logic [XLEN-1:0] PC_FILL  = 64'h0000_0000_8000_1000;
    localparam logic [XLEN-1:0] CSR_FILL = 64'h0000_0000_0000_0300;
    localparam logic [XLEN-1:0] IMM_FILL = 64'hffff_ffff_ffff_fff0;
    localparam logic [XLEN-1:0] MIN_INT  = {1'b1, {(XLEN-1){1'b0}}};

    typedef struct {
        string           name;
        alu_op_e         op;
        sel_a_e          sel_a;
        sel_b_e          sel_b;
        logic            word;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
        logic [XLEN-1:0] csr;
        logic [XLEN-1:0] imm;
        int              flush_after;  // cycles from issue to flush, 0 lets the op finish
        logic [XLEN-1:0] exp;
    } row_t;

    logic            clk;
    logic            rst_n;
    logic            flush;
    logic            in_valid;
    alu_op_e         op;
    sel_a_e          sel_a;
    sel_b_e          sel_b;
    logic            word;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] csr;
    logic [XLEN-1:0] imm;
    logic            in_credit;
    logic            out_valid;
    logic [XLEN-1:0] res;
    logic            out_credit;

    row_t            rows[$];
    logic [31:0]     lfsr;
    int              cycle;
    int              err_count;
    int              credit_pulses;
    int              down_credits;
    int              credit_cap;  // out_credit is pulsed while the count is below this
    int              issue_cycle;
    int              result_cycle;
    logic            held_credit;
    logic            result_seen;
    logic [XLEN-1:0] result_val;

    tb_clkgen #(.PERIOD(40), .RST_CYCLES(10)) u_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    exec_unit #(
        .XLEN        (XLEN),
        .OUT_CREDITS (OUT_CREDITS)
    ) uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .in_valid   (in_valid),
        .op         (op),
        .sel_a      (sel_a),
        .sel_b      (sel_b),
        .word       (word),
        .pc         (pc),
        .rs1        (rs1),
        .rs2        (rs2),
        .csr        (csr),
        .imm        (imm),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .res        (res),
        .out_credit (out_credit)
    );

    task automatic stop_on_error(string msg);
        err_count++;
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_val(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
        if (exp !== act) begin
            err_count++;
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1, one step per bit taken
    function automatic logic [XLEN-1:0] rand_bits(int n);
        logic [XLEN-1:0] v;
        logic            fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[XLEN-2:0], fb};
        end
        return v;
    endfunction

    function automatic logic [XLEN-1:0] ref_result(row_t r);
        logic [XLEN-1:0]        a;
        logic [XLEN-1:0]        b;
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic [XLEN-1:0]        ext;
        logic [5:0]             sh;
        a = (r.sel_a == SEL_A_PC) ? r.pc : r.rs1;
        if (r.word)
            a = {32'h0, a[31:0]};
        case (r.sel_b)
            SEL_B_RS2: b = r.rs2;
            SEL_B_CSR: b = r.csr;
            default:   b = r.imm;
        endcase
        sa = a;
        sb = b;
        sh = b[5:0];
        case (r.op)
            ALU_ADD:    return a + b;
            ALU_SUB:    return a - b;
            ALU_PASS_A: return a;
            ALU_PASS_B: return b;
            ALU_XOR:    return a ^ b;
            ALU_OR:     return a | b;
            ALU_AND:    return a & b;
            ALU_SLL:    return a << sh;
            ALU_SRL:    return a >> sh;
            ALU_SRA: begin
                if (!r.word)
                    return sa >>> sh;
                ext = {{32{a[31]}}, a[31:0]};
                ext = $signed(ext) >>> sh;
                return {32'h0, ext[31:0]};
            end
            ALU_SLT:    return sa < sb;
            ALU_SLTU:   return a < b;
            ALU_EQ:     return a == b;
            ALU_GE:     return sa >= sb;
            ALU_GEU:    return a >= b;
            ALU_MUL:    return a * b;
            ALU_DIVU:   return (b == '0) ? '1 : a / b;
            ALU_REMU:   return (b == '0) ? a : a % b;
            ALU_DIV: begin
                if (b == '0)
                    return '1;
                if (a == MIN_INT && b == '1)
                    return a;
                return sa / sb;
            end
            ALU_REM: begin
                if (b == '0)
                    return a;
                if (a == MIN_INT && b == '1)
                    return '0;
                return sa % sb;
            end
            default:    return '0;
        endcase
    endfunction

    function automatic row_t random_row(alu_op_e o, sel_a_e sa, sel_b_e sb);
        row_t r;
        int   bw;
        // narrow divisors so that quotients are not almost always zero
        bw            = (o inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU}) ? 20 : XLEN;
        r.name        = $sformatf("%s_%0d", o.name(), rows.size());
        r.op          = o;
        r.sel_a       = sa;
        r.sel_b       = sb;
        r.word        = rand_bits(1) != '0;
        r.pc          = rand_bits(XLEN);
        r.rs1         = rand_bits(XLEN);
        r.rs2         = rand_bits(bw);
        r.csr         = rand_bits(bw);
        r.imm         = rand_bits(bw);
        r.flush_after = 0;
        r.exp         = ref_result(r);
        return r;
    endfunction

    task automatic add_row(string name, alu_op_e o, sel_a_e sa, sel_b_e sb, logic w,
                           logic [XLEN-1:0] a_val, logic [XLEN-1:0] b_val, int fa,
                           logic [XLEN-1:0] exp);
        row_t r;
        r.name        = name;
        r.op          = o;
        r.sel_a       = sa;
        r.sel_b       = sb;
        r.word        = w;
        r.pc          = PC_FILL;
        r.rs1         = a_val;
        r.rs2         = b_val;
        r.csr         = CSR_FILL;
        r.imm         = IMM_FILL;
        r.flush_after = fa;
        r.exp         = exp;
        rows.push_back(r);
    endtask

    task automatic add_rr(string name, alu_op_e o, logic w, logic [XLEN-1:0] a_val,
                          logic [XLEN-1:0] b_val, int fa, logic [XLEN-1:0] exp);
        add_row(name, o, SEL_A_RS1, SEL_B_RS2, w, a_val, b_val, fa, exp);
    endtask

    task automatic build_table();
        add_row("add_pc_imm", ALU_ADD, SEL_A_PC, SEL_B_IMM, 0, 0, 0, 0, 64'h0000_0000_8000_0ff0);
        add_row("or_rs1_csr", ALU_OR, SEL_A_RS1, SEL_B_CSR, 0, 64'hf000_0000_0000_0000, 0, 0,
                64'hf000_0000_0000_0300);
        add_row("pass_b_imm", ALU_PASS_B, SEL_A_PC, SEL_B_IMM, 0, 0, 0, 0, IMM_FILL);
        add_rr("sub_wrap", ALU_SUB, 0, 64'h0, 64'h1, 0, '1);
        add_rr("eq_true", ALU_EQ, 0, 64'h1234, 64'h1234, 0, 64'h1);
        add_rr("slt_neg", ALU_SLT, 0, '1, 64'h1, 0, 64'h1);
        add_rr("sltu_neg", ALU_SLTU, 0, '1, 64'h1, 0, 64'h0);
        add_rr("ge_equal", ALU_GE, 0, 64'h5, 64'h5, 0, 64'h1);
        add_rr("pass_a_word", ALU_PASS_A, 1, 64'hdead_beef_1234_5678, 0, 0, 64'h1234_5678);
        add_rr("sra_word", ALU_SRA, 1, 64'hffff_ffff_8000_0000, 64'h4, 0, 64'hf800_0000);
        add_rr("sra_dword", ALU_SRA, 0, MIN_INT, 64'h3f, 0, '1);
        add_rr("sll_top", ALU_SLL, 0, 64'h1, 64'h3f, 0, MIN_INT);
        add_rr("mul_neg", ALU_MUL, 0, '1, 64'h3, 0, 64'hffff_ffff_ffff_fffd);
        add_rr("mul_wrap", ALU_MUL, 0, 64'h1_0000_0001, 64'h1_0000_0001, 0, 64'h2_0000_0001);
        add_rr("div_zero", ALU_DIV, 0, 64'h7, 64'h0, 0, '1);
        add_rr("divu_zero", ALU_DIVU, 0, 64'h7, 64'h0, 0, '1);
        add_rr("rem_zero", ALU_REM, 0, 64'h7, 64'h0, 0, 64'h7);
        add_rr("remu_zero", ALU_REMU, 0, 64'h7, 64'h0, 0, 64'h7);
        add_rr("div_ovf", ALU_DIV, 0, MIN_INT, '1, 0, MIN_INT);
        add_rr("rem_ovf", ALU_REM, 0, MIN_INT, '1, 0, 64'h0);
        add_rr("div_neg", ALU_DIV, 0, 64'hffff_ffff_ffff_fff9, 64'h2, 0, 64'hffff_ffff_ffff_fffd);
        add_rr("rem_neg", ALU_REM, 0, 64'hffff_ffff_ffff_fff9, 64'h2, 0, '1);
        add_rr("div_negdiv", ALU_DIV, 0, 64'h7, 64'hffff_ffff_ffff_fffe, 0, 64'hffff_ffff_ffff_fffd);
        add_rr("rem_negdiv", ALU_REM, 0, 64'h7, 64'hffff_ffff_ffff_fffe, 0, 64'h1);
        // each flushed op is followed by one on the same unit, which must start afresh
        add_rr("mul_flushed", ALU_MUL, 0, 64'h123, 64'h456, 20, 0);
        add_rr("mul_after_flush", ALU_MUL, 0, 64'd6, 64'd7, 0, 64'd42);
        add_rr("divu_flushed", ALU_DIVU, 0, 64'd100, 64'd7, 30, 0);
        add_rr("div_after_flush", ALU_DIV, 0, 64'hffff_ffff_ffff_ff9c, 64'd7, 0,
               64'hffff_ffff_ffff_fff2);
        for (int o = ALU_ADD; o <= ALU_GEU; o++)
            for (int sa = 0; sa < 2; sa++)
                for (int sb = 0; sb < 3; sb++)
                    rows.push_back(random_row(alu_op_e'(o), sel_a_e'(sa), sel_b_e'(sb)));
        for (int o = ALU_MUL; o <= ALU_REMU; o++)
            for (int k = 0; k < 4; k++)
                rows.push_back(random_row(alu_op_e'(o), sel_a_e'(k % 2), sel_b_e'(k % 3)));
    endtask

    // samples the DUT at the falling edge, then drives out_credit for the next cycle
    task automatic next_cycle();
        @(negedge clk);
        cycle++;
        if (in_credit) begin
            credit_pulses++;
            if (held_credit)
                stop_on_error("a second upstream credit arrived while one was held");
            held_credit = 1'b1;
        end
        if (out_valid) begin
            if (down_credits == 0)
                stop_on_error("a result was sent with no downstream credit");
            down_credits--;
            result_seen  = 1'b1;
            result_val   = res;
            result_cycle = cycle;
        end
        out_credit = down_credits < credit_cap;
        if (out_credit)
            down_credits++;
    endtask

    task automatic wait_for_credit(string name);
        for (int n = 0; n < CREDIT_WAIT && !held_credit; n++)
            next_cycle();
        if (!held_credit)
            stop_on_error({"no upstream credit arrived before ", name});
    endtask

    task automatic wait_for_result(string name);
        for (int n = 0; n < RESULT_WAIT && !result_seen; n++)
            next_cycle();
        if (!result_seen)
            stop_on_error({"no result arrived for ", name});
    endtask

    task automatic send_op(row_t r);
        op          = r.op;  // fields stay on the bus after in_valid drops
        sel_a       = r.sel_a;
        sel_b       = r.sel_b;
        word        = r.word;
        pc          = r.pc;
        rs1         = r.rs1;
        rs2         = r.rs2;
        csr         = r.csr;
        imm         = r.imm;
        in_valid    = 1'b1;
        held_credit = 1'b0;
        result_seen = 1'b0;
        issue_cycle = cycle;
        next_cycle();
        in_valid = 1'b0;
    endtask

    task automatic run_row(row_t r);
        logic simple;
        simple = !(r.op inside {ALU_MUL, ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU});
        wait_for_credit(r.name);
        send_op(r);
        if (r.flush_after > 0) begin
            repeat (r.flush_after - 1) next_cycle();
            flush = 1'b1;
            next_cycle();
            flush = 1'b0;
            if (!held_credit)
                stop_on_error({"no upstream credit in the cycle after flushing ", r.name});
            if (result_seen)
                stop_on_error({"a result came out of the flushed op ", r.name});
        end else begin
            wait_for_result(r.name);
            check_val(r.name, r.exp, result_val);
            if (simple)
                check_val({r.name, "_latency"}, 2, result_cycle - issue_cycle);
        end
    endtask

    task automatic back_pressure();
        row_t r;
        for (int n = 0; n < CREDIT_WAIT && down_credits != OUT_CREDITS; n++)
            next_cycle();
        if (down_credits != OUT_CREDITS)
            stop_on_error("downstream credits were not all returned before the stall test");
        credit_cap = 0;
        for (int i = 0; i < OUT_CREDITS; i++)
            run_row(random_row(ALU_ADD, SEL_A_RS1, SEL_B_RS2));
        r      = random_row(ALU_XOR, SEL_A_RS1, SEL_B_CSR);
        r.name = "stalled_xor";
        wait_for_credit(r.name);
        send_op(r);
        repeat (12) begin
            next_cycle();
            if (result_seen)
                stop_on_error("a result came out while downstream credits were withheld");
        end
        if (held_credit)
            stop_on_error("upstream credit came back before the stalled result left");
        credit_cap = 1;  // one out_credit pulse releases the stalled result
        wait_for_result(r.name);
        if (held_credit)
            stop_on_error("upstream credit came back together with the stalled result");
        check_val(r.name, r.exp, result_val);
        credit_cap = OUT_CREDITS;
        wait_for_credit(r.name);
    endtask

    initial begin
        flush         = 1'b0;
        in_valid      = 1'b0;
        op            = ALU_ADD;
        sel_a         = SEL_A_RS1;
        sel_b         = SEL_B_RS2;
        word          = 1'b0;
        pc            = '0;
        rs1           = '0;
        rs2           = '0;
        csr           = '0;
        imm           = '0;
        out_credit    = 1'b0;
        lfsr          = 32'hebfe63c1;
        cycle         = 0;
        err_count     = 0;
        credit_pulses = 0;
        down_credits  = OUT_CREDITS;
        credit_cap    = OUT_CREDITS;
        held_credit   = 1'b0;
        result_seen   = 1'b0;
        build_table();

        for (int n = 0; n < 50 && !rst_n; n++)
            @(posedge clk);
        if (!rst_n)
            stop_on_error("reset was never released");
        repeat (5) next_cycle();
        check_val("reset_credit_pulses", 1, credit_pulses);

        foreach (rows[i])
            run_row(rows[i]);
        back_pressure();

        if (err_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
alu_pkg.sv
alu_simple.sv
iter_mul.sv
iter_div.sv
exec_ctrl.sv
exec_unit.sv
tb_clkgen.sv
exec_unit_tb.sv

/* Bender.yml */
package:
  name: exec_unit

sources:
  - alu_pkg.sv
  - alu_simple.sv
  - iter_mul.sv
  - iter_div.sv
  - exec_ctrl.sv
  - exec_unit.sv
  - target: test
    files:
      - tb_clkgen.sv
      - exec_unit_tb.sv
